//--- armPkg.sv
// ##################
// Shared types and decoder constants for the single-cycle ARM core
// Condition code 4'b1111 has no enumerator and never executes
// ##################
`default_nettype none

package armPkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // Register number, r15 is the PC
    typedef logic [3:0] regIdx_t;

    // Data-processing opcodes in instruction encoding order
    typedef enum logic [3:0] {
        CMD_AND, CMD_EOR, CMD_SUB, CMD_RSB,
        CMD_ADD, CMD_ADC, CMD_SBC, CMD_RSC,
        CMD_TST, CMD_TEQ, CMD_CMP, CMD_CMN,
        CMD_ORR, CMD_MOV, CMD_BIC, CMD_MVN
    } aluCmd_t;

    // Condition field, EQ through AL
    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC,
        COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT,
        COND_GT, COND_LE, COND_AL
    } cond_t;

    // Status flags, N in the top bit
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    localparam regIdx_t PC_REG   = 4'd15;
    localparam regIdx_t LINK_REG = 4'd14;

    // Instruction classes from instr[27:26]
    localparam logic [1:0] OP_DP  = 2'b00;
    localparam logic [1:0] OP_MEM = 2'b01;
    localparam logic [1:0] OP_BR  = 2'b10;

    // Immediate extension selects
    localparam logic [1:0] IMM_DP  = 2'b00;
    localparam logic [1:0] IMM_MEM = 2'b01;
    localparam logic [1:0] IMM_BR  = 2'b10;

endpackage

`default_nettype wire

//--- decoder.sv
// ##################
// Main and ALU decoder, purely combinational
// Memory ops assume an immediate offset, class 2'b11 decodes to a no-op
// ##################
`timescale 1ns/1ps
`default_nettype none

module decoder import armPkg::*; (
    input  logic [1:0] op,
    input  logic [5:0] funct,
    input  regIdx_t    rd,
    output logic [1:0] regSrc,
    output logic [1:0] immSrc,
    output logic       aluSrc,
    output logic       memToReg,
    output logic       regWrite,
    output logic       memWrite,
    output logic       branch,
    output logic       byteEnable,
    output logic       linkWrite,
    output aluCmd_t    aluControl,
    output logic [1:0] flagWrite,
    output logic       pcSrc
);

    logic aluOp;
    logic isCompare;

    // TST, TEQ, CMP and CMN only touch the flags
    assign isCompare = (funct[4:3] == 2'b10);

    // Main decoder
    always_comb begin
        regSrc     = 2'b00;
        immSrc     = IMM_DP;
        aluSrc     = 1'b0;
        memToReg   = 1'b0;
        regWrite   = 1'b0;
        memWrite   = 1'b0;
        branch     = 1'b0;
        byteEnable = 1'b0;
        linkWrite  = 1'b0;
        aluOp      = 1'b0;
        case (op)
            OP_DP: begin
                // I bit picks imm8 over Rm
                aluSrc   = funct[5];
                regWrite = !isCompare;
                aluOp    = 1'b1;
            end
            OP_MEM: begin
                immSrc     = IMM_MEM;
                aluSrc     = 1'b1;
                byteEnable = funct[2];
                if (funct[0]) begin
                    memToReg = 1'b1;
                    regWrite = 1'b1;
                end else begin
                    // Store reads Rd through the second port
                    regSrc[1] = 1'b1;
                    memWrite  = 1'b1;
                end
            end
            OP_BR: begin
                // Target is PC+8 plus offset
                regSrc[0] = 1'b1;
                immSrc    = IMM_BR;
                aluSrc    = 1'b1;
                branch    = 1'b1;
                linkWrite = funct[4];
            end
            default: ;
        endcase
    end

    // ALU decoder, ADD for address and target math
    always_comb begin
        if (aluOp) begin
            aluControl   = aluCmd_t'(funct[4:1]);
            flagWrite[1] = funct[0];
            // C and V only from arithmetic
            flagWrite[0] = funct[0] && (aluControl inside {CMD_SUB, CMD_RSB, CMD_ADD,
                CMD_ADC, CMD_SBC, CMD_RSC, CMD_CMP, CMD_CMN});
        end else begin
            aluControl = CMD_ADD;
            flagWrite  = 2'b00;
        end
    end

    // Writing r15 is a jump
    assign pcSrc = branch || (regWrite && rd == PC_REG);

    always_comb begin
        if (op inside {OP_DP, OP_MEM, OP_BR})
            assert final (!$isunknown(aluControl))
                else $error("aluControl unknown for a valid class");
    end

endmodule

`default_nettype wire

//--- condLogic.sv
// ##################
// Flag register and condition check
// Writes are dropped and flags clear while in reset
// ##################
`timescale 1ns/1ps
`default_nettype none

module condLogic import armPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cond_t      cond,
    input  flags_t     aluFlags,
    input  logic [1:0] flagWrite,
    input  logic       pcSrc,
    input  logic       regWrite,
    input  logic       memWrite,
    input  logic       linkWrite,
    output logic       pcWrite,
    output logic       regWriteOk,
    output logic       memWriteOk,
    output logic       linkWriteOk,
    output logic       carryFlag
);

    flags_t flags;
    logic   condEx;

    // Condition against the stored flags
    always_comb begin
        case (cond)
            COND_EQ: condEx = flags.z;
            COND_NE: condEx = !flags.z;
            COND_CS: condEx = flags.c;
            COND_CC: condEx = !flags.c;
            COND_MI: condEx = flags.n;
            COND_PL: condEx = !flags.n;
            COND_VS: condEx = flags.v;
            COND_VC: condEx = !flags.v;
            COND_HI: condEx = flags.c && !flags.z;
            COND_LS: condEx = !flags.c || flags.z;
            COND_GE: condEx = (flags.n == flags.v);
            COND_LT: condEx = (flags.n != flags.v);
            COND_GT: condEx = !flags.z && (flags.n == flags.v);
            COND_LE: condEx = flags.z || (flags.n != flags.v);
            COND_AL: condEx = 1'b1;
            // Reserved code never runs
            default: condEx = 1'b0;
        endcase
    end

    // NZ and CV halves update separately
    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else begin
            if (flagWrite[1] && condEx) begin
                flags.n <= aluFlags.n;
                flags.z <= aluFlags.z;
            end
            if (flagWrite[0] && condEx) begin
                flags.c <= aluFlags.c;
                flags.v <= aluFlags.v;
            end
        end
    end

    assign pcWrite     = pcSrc && condEx;
    assign regWriteOk  = regWrite && condEx && !rst;
    assign memWriteOk  = memWrite && condEx && !rst;
    assign linkWriteOk = linkWrite && condEx && !rst;
    // Stored C feeds ADC, SBC and RSC
    assign carryFlag   = flags.c;

    // A store never also writes a register or the PC
    assert property (@(posedge clk) disable iff (rst)
        !(memWriteOk && (regWriteOk || pcWrite)))
        else $error("store strobe together with a register or PC write");

endmodule

`default_nettype wire

//--- regFile.sv
// ##################
// Fifteen registers, two async reads, one sync write
// r15 is not stored here, reads of it return PC+8
// ##################
`timescale 1ns/1ps
`default_nettype none

module regFile import armPkg::*; (
    input  logic    clk,
    input  logic    we,
    input  regIdx_t ra1,
    input  regIdx_t ra2,
    input  regIdx_t wa,
    input  word_t   wd,
    input  word_t   pcPlus8,
    output word_t   rd1,
    output word_t   rd2
);

    word_t regs [0:14];

    always_ff @(posedge clk) begin
        if (we)
            regs[wa] <= wd;
    end

    assign rd1 = (ra1 == PC_REG) ? pcPlus8 : regs[ra1];
    assign rd2 = (ra2 == PC_REG) ? pcPlus8 : regs[ra2];

    // Datapath must route r15 writes to the PC
    assert property (@(posedge clk) we |-> wa != PC_REG)
        else $error("register write aimed at r15");

endmodule

`default_nettype wire

//--- alu.sv
// ##################
// Sixteen data-processing ops on one shared adder
// Logical ops pass carryIn through to C and clear V
// ##################
`timescale 1ns/1ps
`default_nettype none

module alu import armPkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  aluCmd_t cmd,
    input  logic    carryIn,
    output word_t   result,
    output flags_t  flags
);

    word_t       x;
    word_t       y;
    logic        cin;
    logic [32:0] sum;
    logic        isArith;
    logic        overflow;

    // Adder inputs, subtraction as invert plus one
    always_comb begin
        x   = a;
        y   = b;
        cin = 1'b0;
        case (cmd)
            CMD_SUB, CMD_CMP: begin
                y   = ~b;
                cin = 1'b1;
            end
            CMD_RSB: begin
                x   = ~a;
                cin = 1'b1;
            end
            CMD_ADC: cin = carryIn;
            CMD_SBC: begin
                y   = ~b;
                cin = carryIn;
            end
            CMD_RSC: begin
                x   = ~a;
                cin = carryIn;
            end
            default: ;
        endcase
    end

    assign sum      = {1'b0, x} + {1'b0, y} + {32'd0, cin};
    // Same-sign inputs giving a different-sign sum
    assign overflow = (x[31] == y[31]) && (sum[31] != x[31]);
    assign isArith  = cmd inside {CMD_SUB, CMD_RSB, CMD_ADD, CMD_ADC,
        CMD_SBC, CMD_RSC, CMD_CMP, CMD_CMN};

    always_comb begin
        case (cmd)
            CMD_AND, CMD_TST: result = a & b;
            CMD_EOR, CMD_TEQ: result = a ^ b;
            CMD_ORR: result = a | b;
            CMD_MOV: result = b;
            CMD_BIC: result = a & ~b;
            CMD_MVN: result = ~b;
            default: result = sum[31:0];
        endcase
    end

    // Carry out is the inverted borrow for subtracts
    assign flags.n = result[31];
    assign flags.z = (result == '0);
    assign flags.c = isArith ? sum[32] : carryIn;
    assign flags.v = isArith && overflow;

endmodule

`default_nettype wire

//--- datapath.sv
// ##################
// PC, register file, immediates, ALU and result muxing
// readData is the aligned word, byte loads pick the lane here
// Immediate rotate field is ignored, imm8 is zero-extended
// ##################
`timescale 1ns/1ps
`default_nettype none

module datapath import armPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  word_t      instr,
    input  word_t      readData,
    input  logic [1:0] regSrc,
    input  logic [1:0] immSrc,
    input  logic       aluSrc,
    input  logic       memToReg,
    input  logic       byteEnable,
    input  logic       regWriteOk,
    input  logic       linkWriteOk,
    input  logic       pcWrite,
    input  aluCmd_t    aluControl,
    input  logic       carryFlag,
    output word_t      pc,
    output word_t      aluResult,
    output word_t      writeData,
    output flags_t     aluFlags
);

    word_t      pcPlus4;
    word_t      pcPlus8;
    word_t      extImm;
    word_t      srcA;
    word_t      srcB;
    word_t      memValue;
    word_t      result;
    word_t      wd;
    regIdx_t    ra1;
    regIdx_t    ra2;
    regIdx_t    wa;
    logic       we;
    logic [7:0] loadByte;

    assign pcPlus4 = pc + 32'd4;
    assign pcPlus8 = pcPlus4 + 32'd4;

    // Next PC is the result on a taken jump
    always_ff @(posedge clk) begin
        if (rst)
            pc <= '0;
        else
            pc <= pcWrite ? result : pcPlus4;
    end

    // Branches read r15, stores read Rd on port two
    assign ra1 = regSrc[0] ? PC_REG : instr[19:16];
    assign ra2 = regSrc[1] ? instr[15:12] : instr[3:0];

    always_comb begin
        case (immSrc)
            IMM_DP:  extImm = {24'd0, instr[7:0]};
            IMM_MEM: extImm = {20'd0, instr[11:0]};
            // Word offset, sign-extended
            IMM_BR:  extImm = {{6{instr[23]}}, instr[23:0], 2'b00};
            default: extImm = '0;
        endcase
    end

    // BL puts the return address in r14
    assign wa = linkWriteOk ? LINK_REG : instr[15:12];
    assign wd = linkWriteOk ? pcPlus4 : result;
    // r15 destination goes to the PC instead
    assign we = (regWriteOk && instr[15:12] != PC_REG) || linkWriteOk;

    regFile rf (
        .clk     (clk),
        .we      (we),
        .ra1     (ra1),
        .ra2     (ra2),
        .wa      (wa),
        .wd      (wd),
        .pcPlus8 (pcPlus8),
        .rd1     (srcA),
        .rd2     (writeData)
    );

    assign srcB = aluSrc ? extImm : writeData;

    alu aluUnit (
        .a       (srcA),
        .b       (srcB),
        .cmd     (aluControl),
        .carryIn (carryFlag),
        .result  (aluResult),
        .flags   (aluFlags)
    );

    // Byte lane by address, little endian
    always_comb begin
        case (aluResult[1:0])
            2'd0:    loadByte = readData[7:0];
            2'd1:    loadByte = readData[15:8];
            2'd2:    loadByte = readData[23:16];
            default: loadByte = readData[31:24];
        endcase
    end

    assign memValue = byteEnable ? {24'd0, loadByte} : readData;
    assign result   = memToReg ? memValue : aluResult;

endmodule

`default_nettype wire

//--- armCore.sv
// ##################
// Single-cycle core top, one instruction per clock
// Memories are external with combinational reads
// ##################
`timescale 1ns/1ps
`default_nettype none

module armCore import armPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t instr,
    input  word_t readData,
    output word_t pc,
    output word_t dataAdr,
    output word_t writeData,
    output logic  memWrite,
    output logic  byteEnable
);

    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic [1:0] flagWrite;
    logic       aluSrc;
    logic       memToReg;
    logic       regWrite;
    logic       memWriteReq;
    logic       linkWrite;
    logic       pcSrc;
    logic       pcWrite;
    logic       regWriteOk;
    logic       linkWriteOk;
    logic       carryFlag;
    aluCmd_t    aluControl;
    flags_t     aluFlags;

    // Branch is already folded into pcSrc
    decoder dec (
        .op         (instr[27:26]),
        .funct      (instr[25:20]),
        .rd         (instr[15:12]),
        .regSrc     (regSrc),
        .immSrc     (immSrc),
        .aluSrc     (aluSrc),
        .memToReg   (memToReg),
        .regWrite   (regWrite),
        .memWrite   (memWriteReq),
        .branch     (),
        .byteEnable (byteEnable),
        .linkWrite  (linkWrite),
        .aluControl (aluControl),
        .flagWrite  (flagWrite),
        .pcSrc      (pcSrc)
    );

    condLogic cl (
        .clk         (clk),
        .rst         (rst),
        .cond        (cond_t'(instr[31:28])),
        .aluFlags    (aluFlags),
        .flagWrite   (flagWrite),
        .pcSrc       (pcSrc),
        .regWrite    (regWrite),
        .memWrite    (memWriteReq),
        .linkWrite   (linkWrite),
        .pcWrite     (pcWrite),
        .regWriteOk  (regWriteOk),
        .memWriteOk  (memWrite),
        .linkWriteOk (linkWriteOk),
        .carryFlag   (carryFlag)
    );

    datapath dp (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .readData    (readData),
        .regSrc      (regSrc),
        .immSrc      (immSrc),
        .aluSrc      (aluSrc),
        .memToReg    (memToReg),
        .byteEnable  (byteEnable),
        .regWriteOk  (regWriteOk),
        .linkWriteOk (linkWriteOk),
        .pcWrite     (pcWrite),
        .aluControl  (aluControl),
        .carryFlag   (carryFlag),
        .pc          (pc),
        .aluResult   (dataAdr),
        .writeData   (writeData),
        .aluFlags    (aluFlags)
    );

endmodule

`default_nettype wire

//--- armCoreTb.sv
// ##################
// Random-instruction testbench for the single-cycle core
// Base register r13 is held at 0, so loads and stores hit a 64-word window
// Random writes never target r13 or r15
// ##################
`timescale 1ns/1ps
`default_nettype none

module armCoreTb import armPkg::*; ();

    localparam logic [31:0] SEED = 32'hccef_a1ef;
    localparam int NUM_RANDOM  = 2000;
    // Reset, register setup, random run, register dump, plus margin
    localparam int CYCLE_LIMIT = 3 + 15 + NUM_RANDOM + 16 + 200;

    logic  clk = 1'b0;
    logic  rst = 1'b1;
    // Store held on the bus during reset
    word_t instr = 32'hE58D_0000;
    word_t readData;
    word_t pc;
    word_t dataAdr;
    word_t writeData;
    logic  memWrite;
    logic  byteEnable;

    // Memory seen by the DUT and the reference copy
    word_t dataMem [0:63];
    word_t refMem  [0:63];

    // Reference model state
    word_t       regs [0:14];
    flags_t      mFlags;
    word_t       mPc;
    logic [31:0] rngState;
    int          wordErrors;
    int          bitErrors;
    int          cycleCount = 0;

    armCore uut (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .readData   (readData),
        .pc         (pc),
        .dataAdr    (dataAdr),
        .writeData  (writeData),
        .memWrite   (memWrite),
        .byteEnable (byteEnable)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // Data memory with combinational read
    assign readData = dataMem[dataAdr[7:2]];

    always @(posedge clk) begin
        if (memWrite) begin
            if (byteEnable)
                dataMem[dataAdr[7:2]][8 * dataAdr[1:0] +: 8] <= writeData[7:0];
            else
                dataMem[dataAdr[7:2]] <= writeData;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Error counts: word %0d, strobe %0d", wordErrors, bitErrors);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            wordErrors++;
            $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            bitErrors++;
            $display("Fail t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Register read as the architecture sees it
    function automatic word_t readReg(input regIdx_t idx);
        return (idx == 4'd15) ? mPc + 32'd8 : regs[idx];
    endfunction

    // Odd codes negate the even code below them
    function automatic logic condPasses(input logic [3:0] c, input flags_t f);
        logic base;
        case (c[3:1])
            3'd0: base = f.z;
            3'd1: base = f.c;
            3'd2: base = f.n;
            3'd3: base = f.v;
            3'd4: base = f.c && !f.z;
            3'd5: base = (f.n == f.v);
            3'd6: base = !f.z && (f.n == f.v);
            default: base = 1'b1;
        endcase
        return c[0] ? !base : base;
    endfunction

    // Wide signed and unsigned sums give C and V directly
    task automatic modelAlu(input aluCmd_t cmd, input word_t a, input word_t b,
                            input flags_t fIn, output word_t res, output flags_t fOut);
        longint ua;
        longint ub;
        longint sa;
        longint sb;
        longint ci;
        longint full;
        longint sfull;
        logic   arith;
        logic   isSub;
        ua    = {32'd0, a};
        ub    = {32'd0, b};
        sa    = $signed(a);
        sb    = $signed(b);
        ci    = fIn.c;
        arith = 1'b1;
        isSub = 1'b1;
        full  = 0;
        sfull = 0;
        res   = '0;
        case (cmd)
            CMD_AND, CMD_TST: begin
                res   = a & b;
                arith = 1'b0;
            end
            CMD_EOR, CMD_TEQ: begin
                res   = a ^ b;
                arith = 1'b0;
            end
            CMD_ORR: begin
                res   = a | b;
                arith = 1'b0;
            end
            CMD_MOV: begin
                res   = b;
                arith = 1'b0;
            end
            CMD_BIC: begin
                res   = a & ~b;
                arith = 1'b0;
            end
            CMD_MVN: begin
                res   = ~b;
                arith = 1'b0;
            end
            CMD_SUB, CMD_CMP: begin
                full  = ua - ub;
                sfull = sa - sb;
            end
            CMD_RSB: begin
                full  = ub - ua;
                sfull = sb - sa;
            end
            CMD_SBC: begin
                full  = ua - ub - (1 - ci);
                sfull = sa - sb - (1 - ci);
            end
            CMD_RSC: begin
                full  = ub - ua - (1 - ci);
                sfull = sb - sa - (1 - ci);
            end
            CMD_ADD, CMD_CMN: begin
                isSub = 1'b0;
                full  = ua + ub;
                sfull = sa + sb;
            end
            default: begin
                // ADC
                isSub = 1'b0;
                full  = ua + ub + ci;
                sfull = sa + sb + ci;
            end
        endcase
        if (arith)
            res = full[31:0];
        fOut   = fIn;
        fOut.n = res[31];
        fOut.z = (res == '0);
        if (arith) begin
            // Subtract carry means no borrow
            fOut.c = isSub ? (full >= 0) : full[32];
            fOut.v = (sfull > 64'sd2147483647) || (sfull < -64'sd2147483648);
        end
    endtask

    // Checks the DUT against this instruction and executes it in the model
    task automatic runStep(input word_t ins);
        logic [1:0] op;
        logic       ok;
        logic       isStore;
        logic       isLoad;
        logic       isByte;
        regIdx_t    rn;
        regIdx_t    rd;
        aluCmd_t    cmd;
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      addr;
        word_t      val;
        word_t      nextPc;
        flags_t     f;
        op      = ins[27:26];
        ok      = condPasses(ins[31:28], mFlags);
        rn      = ins[19:16];
        rd      = ins[15:12];
        isStore = (op == OP_MEM) && !ins[20];
        isLoad  = (op == OP_MEM) && ins[20];
        isByte  = (op == OP_MEM) && ins[22];
        nextPc  = mPc + 32'd4;
        checkWord("pc", pc, mPc);
        checkBit("memWrite", memWrite, isStore && ok);
        checkBit("byteEnable", byteEnable, isByte);
        case (op)
            OP_DP: begin
                cmd = aluCmd_t'(ins[24:21]);
                a   = readReg(rn);
                b   = ins[25] ? {24'd0, ins[7:0]} : readReg(ins[3:0]);
                modelAlu(cmd, a, b, mFlags, res, f);
                if (ok) begin
                    if (ins[20])
                        mFlags = f;
                    // Compare and test ops leave Rd alone
                    if (cmd[3:2] != 2'b10)
                        regs[rd] = res;
                end
            end
            OP_MEM: begin
                addr = readReg(rn) + {20'd0, ins[11:0]};
                checkWord("dataAdr", dataAdr, addr);
                if (isStore) begin
                    val = readReg(rd);
                    checkWord("writeData", writeData, val);
                    if (ok && isByte)
                        refMem[addr[7:2]][8 * addr[1:0] +: 8] = val[7:0];
                    else if (ok)
                        refMem[addr[7:2]] = val;
                end
                if (isLoad && ok) begin
                    val = refMem[addr[7:2]];
                    if (isByte)
                        val = {24'd0, val[8 * addr[1:0] +: 8]};
                    regs[rd] = val;
                end
            end
            default: begin
                if (ok) begin
                    nextPc = mPc + 32'd8 + {{6{ins[23]}}, ins[23:0], 2'b00};
                    // BL return address
                    if (ins[24])
                        regs[LINK_REG] = mPc + 32'd4;
                end
            end
        endcase
        mPc = nextPc;
    endtask

    // Random supported encoding with about half the instructions conditional
    function automatic word_t randomInstr(input word_t pcNow);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [3:0]  cnd;
        logic [3:0]  cmd;
        logic [11:0] op2;
        logic [11:0] imm12;
        logic        sBit;
        regIdx_t     rd;
        regIdx_t     rn;
        word_t       diff;
        r1  = nextRandom();
        r2  = nextRandom();
        cnd = r1[31] ? 4'hE : 4'(r1[3:0] % 15);
        rd  = r2[3:0];
        if (rd == 4'd13 || rd == 4'd15)
            rd = rd - 4'd1;
        if (r1[7:4] < 4'd10) begin
            cmd  = r1[11:8];
            sBit = r1[12];
            rn   = r2[7:4];
            op2  = r1[13] ? r2[23:12] : {8'd0, r2[11:8]};
            if (cmd[3:2] == 2'b10) begin
                sBit = 1'b1;
                rd   = 4'd0;
            end
            if (cmd == CMD_MOV || cmd == CMD_MVN)
                rn = 4'd0;
            return {cnd, 2'b00, r1[13], cmd, sBit, rn, rd, op2};
        end else if (r1[7:4] < 4'd14) begin
            // Word offsets stay aligned
            imm12 = r1[15] ? {4'd0, r2[27:20]} : {4'd0, r2[25:20], 2'b00};
            if (!r1[14])
                rd = r2[3:0];
            return {cnd, 2'b01, 3'b011, r1[15], 1'b0, r1[14], 4'd13, rd, imm12};
        end else begin
            // Target word taken from the low 256 words
            diff = {24'd0, r2[31:24]} - (pcNow >> 2) - 32'd2;
            return {cnd, 3'b101, r1[16], diff[23:0]};
        end
    endfunction

    task automatic issue(input word_t ins);
        instr <= ins;
        @(negedge clk);
        runStep(ins);
        @(posedge clk);
    endtask

    initial begin
        mPc        = '0;
        mFlags     = '0;
        rngState   = SEED;
        wordErrors = 0;
        bitErrors  = 0;
        for (int i = 0; i < 64; i++) begin
            refMem[i]  = (word_t'(i) * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
            dataMem[i] <= refMem[i];
        end
        repeat (2) begin
            @(negedge clk);
            checkBit("memWrite", memWrite, 1'b0);
        end
        @(posedge clk);
        rst <= 1'b0;

        // MOV a small value into each register and zero into r13
        for (int i = 0; i < 15; i++)
            issue({4'hE, 8'h3A, 4'd0, regIdx_t'(i), 4'd0,
                   (i == 13) ? 8'd0 : 8'(nextRandom())});

        for (int n = 0; n < NUM_RANDOM; n++)
            issue(randomInstr(mPc));

        // Dump registers to memory, then a MOV r0, r0 lets the last store land
        for (int i = 0; i < 15; i++)
            issue({4'hE, 8'h58, 4'd13, regIdx_t'(i), 12'(i * 4)});
        issue(32'hE1A0_0000);

        for (int i = 0; i < 64; i++)
            checkWord($sformatf("dataMem[%0d]", i), dataMem[i], refMem[i]);

        $display("Error counts: word %0d, strobe %0d", wordErrors, bitErrors);
        if (wordErrors == 0 && bitErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
armPkg.sv
decoder.sv
condLogic.sv
regFile.sv
alu.sv
datapath.sv
armCore.sv
armCoreTb.sv
